// ==== comp_phase.hex ====
000
02B
057
082
0AD
0D9
104
12F
15B
186
1B2
1DD
208
234
25F
28A
2B6
2E1
30C
338
363
38E
3BA
3E5
411
43C
467
493
4BE
4E9
515
540

// ==== hdl/clk_ctrl_pkg.sv ====
package clk_ctrl_pkg;

	// ------------------------------------------------------------------------
	// Field widths
	// ------------------------------------------------------------------------

	// Comparator phase code, 32 settings per clock cycle
	localparam int CMP_CODE_W = 5;
	// Fine-step phase, 0 to 1344 steps per 25 ns
	localparam int PHASE_W = 11;
	// Sample phase select, bit 2 flips the 20 MHz parity
	localparam int SAMP_SEL_W = 3;
	localparam int WB_ADDR_W = 2;
	localparam int WB_DATA_W = 32;

	// Register word addresses
	localparam logic [WB_ADDR_W-1:0] ADDR_CTRL = 2'd0;
	localparam logic [WB_ADDR_W-1:0] ADDR_STATUS = 2'd1;

	// CTRL field positions
	localparam int CTRL_CODE_LSB = 0;
	localparam int CTRL_SAMP_LSB = 8;
	localparam int CTRL_SRST_BIT = 16;

	// STATUS field positions
	localparam int STAT_PHASE_LSB = 0;
	localparam int STAT_BUSY_BIT = 12;
	localparam int STAT_LOCK_BIT = 13;
	localparam int STAT_HOLD_BIT = 14;
	localparam int STAT_STATE_LSB = 16;

	// Phase stepper states, readable in STATUS
	typedef enum logic [2:0] {IDLE = 3'd0, REQ = 3'd1, WAIT_DONE = 3'd2, SETTLE = 3'd3} phs_state_t;

endpackage

// ==== hdl/clk_ctrl_regs.sv ====
module clk_ctrl_regs (
	input  logic CLK40,
	input  logic RST,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [clk_ctrl_pkg::WB_ADDR_W-1:0] wb_adr,
	input  logic [clk_ctrl_pkg::WB_DATA_W-1:0] wb_dat_w,
	input  logic [clk_ctrl_pkg::PHASE_W-1:0] cur_phase,
	input  logic busy,
	input  clk_ctrl_pkg::phs_state_t state,
	input  logic cmp_locked,
	input  logic dsr_resync,
	output logic [clk_ctrl_pkg::WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	output logic [clk_ctrl_pkg::CMP_CODE_W-1:0] cmp_code,
	output logic [clk_ctrl_pkg::SAMP_SEL_W-1:0] samp_phase,
	output logic samp_chng,
	output logic soft_rst
);
	import clk_ctrl_pkg::*;

	logic ack_hold;
	logic wb_req;
	logic ctrl_wr;
	logic [SAMP_SEL_W-1:0] samp_wr_val;
	logic [WB_DATA_W-1:0] ctrl_word;
	logic [WB_DATA_W-1:0] status_word;

	// New access only when no ack is out and stb has dropped since the last one
	assign wb_req = wb_cyc && wb_stb && !wb_ack && !ack_hold;
	assign ctrl_wr = wb_req && wb_we && (wb_adr == ADDR_CTRL);
	assign samp_wr_val = wb_dat_w[CTRL_SAMP_LSB +: SAMP_SEL_W];

	// ------------------------------------------------------------------------
	// Single-cycle ack
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			wb_ack <= 1'b0;
			ack_hold <= 1'b0;
		end
		else
		begin
			wb_ack <= wb_req;
			// Hold off until the master releases stb
			if (!(wb_cyc && wb_stb))
				ack_hold <= 1'b0;
			else if (wb_ack)
				ack_hold <= 1'b1;
		end
	end

	// Control register, new value visible in the ack cycle
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			cmp_code <= '0;
			samp_phase <= '0;
			soft_rst <= 1'b0;
			samp_chng <= 1'b0;
		end
		else
		begin
			samp_chng <= 1'b0;
			if (ctrl_wr)
			begin
				cmp_code <= wb_dat_w[CTRL_CODE_LSB +: CMP_CODE_W];
				samp_phase <= samp_wr_val;
				soft_rst <= wb_dat_w[CTRL_SRST_BIT];
				// Realign only on a real change of the sample field
				samp_chng <= (samp_wr_val != samp_phase);
			end
		end
	end

	// Read mux
	always_comb
	begin
		ctrl_word = '0;
		ctrl_word[CTRL_CODE_LSB +: CMP_CODE_W] = cmp_code;
		ctrl_word[CTRL_SAMP_LSB +: SAMP_SEL_W] = samp_phase;
		ctrl_word[CTRL_SRST_BIT] = soft_rst;
		status_word = '0;
		status_word[STAT_PHASE_LSB +: PHASE_W] = cur_phase;
		status_word[STAT_BUSY_BIT] = busy;
		status_word[STAT_LOCK_BIT] = cmp_locked;
		status_word[STAT_HOLD_BIT] = dsr_resync;
		status_word[STAT_STATE_LSB +: $bits(phs_state_t)] = state;
		case (wb_adr)
			ADDR_CTRL: wb_dat_r = ctrl_word;
			ADDR_STATUS: wb_dat_r = status_word;
			default: wb_dat_r = '0;
		endcase
	end

endmodule

// ==== hdl/clk_ctrl_top.sv ====
module clk_ctrl_top #(
	parameter int TICK_DIV = 40,
	parameter int HOLDOFF_US = 100
) (
	input  logic CLK40,
	input  logic RST,
	input  logic wb_cyc,
	input  logic wb_stb,
	input  logic wb_we,
	input  logic [clk_ctrl_pkg::WB_ADDR_W-1:0] wb_adr,
	input  logic [clk_ctrl_pkg::WB_DATA_W-1:0] wb_dat_w,
	output logic [clk_ctrl_pkg::WB_DATA_W-1:0] wb_dat_r,
	output logic wb_ack,
	input  logic resync,
	output logic ps_en,
	output logic ps_incdec,
	input  logic ps_done,
	input  logic cmp_locked,
	output logic cmp_rst,
	output logic samp_mmcm_rst,
	output logic [1:0] samp_sel,
	output logic clk20_sel,
	output logic dsr_resync,
	output logic cmp_phs_change
);
	import clk_ctrl_pkg::*;

	logic [CMP_CODE_W-1:0] cmp_code;
	logic [PHASE_W-1:0] target_phase;
	logic [PHASE_W-1:0] cur_phase;
	logic busy;
	phs_state_t state;
	logic [SAMP_SEL_W-1:0] samp_phase;
	logic samp_chng;
	logic soft_rst;

	// Comparator clock manager and stepper share this reset
	assign cmp_rst = RST | soft_rst;

	// ------------------------------------------------------------------------
	// Register access
	// ------------------------------------------------------------------------
	clk_ctrl_regs u_regs (
		.CLK40(CLK40), .RST(RST),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .cur_phase(cur_phase), .busy(busy), .state(state),
		.cmp_locked(cmp_locked), .dsr_resync(dsr_resync),
		.wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .cmp_code(cmp_code),
		.samp_phase(samp_phase), .samp_chng(samp_chng), .soft_rst(soft_rst)
	);

	// Comparator phase path, table then stepper
	cmp_phase_rom u_rom (
		.CLK40(CLK40), .cmp_code(cmp_code), .target_phase(target_phase)
	);

	cmp_phase_stepper u_stepper (
		.CLK40(CLK40), .cmp_rst(cmp_rst), .target_phase(target_phase),
		.cmp_locked(cmp_locked), .ps_done(ps_done), .ps_en(ps_en),
		.ps_incdec(ps_incdec), .cur_phase(cur_phase), .busy(busy), .state(state),
		.cmp_phs_change(cmp_phs_change)
	);

	// Sample clock realignment
	samp_resync_ctrl #(.TICK_DIV(TICK_DIV), .HOLDOFF_US(HOLDOFF_US)) u_resync (
		.CLK40(CLK40), .RST(RST), .resync(resync), .samp_phase(samp_phase),
		.samp_chng(samp_chng), .samp_mmcm_rst(samp_mmcm_rst), .samp_sel(samp_sel),
		.clk20_sel(clk20_sel), .dsr_resync(dsr_resync)
	);

endmodule

// ==== hdl/cmp_phase_rom.sv ====
module cmp_phase_rom (
	input  logic CLK40,
	input  logic [clk_ctrl_pkg::CMP_CODE_W-1:0] cmp_code,
	output logic [clk_ctrl_pkg::PHASE_W-1:0] target_phase
);
	import clk_ctrl_pkg::*;

	// ------------------------------------------------------------------------
	// Phase code to fine-step table
	// ------------------------------------------------------------------------

	// One entry per code
	localparam int DEPTH = 2 ** CMP_CODE_W;

	// Fine step is 1/56 of the VCO period at 24 x 40 MHz,
	// so one 25 ns cycle spans 1344 steps
	// Entry i holds i * 1344 / 31, rounded
	logic [PHASE_W-1:0] phase_rom [0:DEPTH-1];

	initial
	begin
		$readmemh("comp_phase.hex", phase_rom);
	end

	// Registered lookup
	// target follows cmp_code one cycle later
	always_ff @(posedge CLK40)
	begin
		target_phase <= phase_rom[cmp_code];
	end

endmodule

// ==== hdl/cmp_phase_stepper.sv ====
module cmp_phase_stepper (
	input  logic CLK40,
	input  logic cmp_rst,
	input  logic [clk_ctrl_pkg::PHASE_W-1:0] target_phase,
	input  logic cmp_locked,
	input  logic ps_done,
	output logic ps_en,
	output logic ps_incdec,
	output logic [clk_ctrl_pkg::PHASE_W-1:0] cur_phase,
	output logic busy,
	output clk_ctrl_pkg::phs_state_t state,
	output logic cmp_phs_change
);
	import clk_ctrl_pkg::*;

	phs_state_t state_nxt;
	logic phase_diff;
	logic step_inc;
	logic chg_m1;

	assign phase_diff = (target_phase != cur_phase);

	// ------------------------------------------------------------------------
	// Request FSM, one fine step per request
	// ------------------------------------------------------------------------
	always_ff @(posedge CLK40 or posedge cmp_rst)
	begin
		if (cmp_rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			// No request while the clock manager is unlocked
			IDLE:
				if (phase_diff && cmp_locked)
					state_nxt = REQ;
			REQ:
				state_nxt = WAIT_DONE;
			// Wait as long as the manager takes
			WAIT_DONE:
				if (ps_done)
					state_nxt = SETTLE;
			SETTLE:
				state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	// Presumed phase inside the clock manager
	// Must match its preset phase after reset, normally 0
	always_ff @(posedge CLK40 or posedge cmp_rst)
	begin
		if (cmp_rst)
		begin
			cur_phase <= '0;
			step_inc <= 1'b0;
		end
		else
		begin
			// Direction frozen for the whole request
			if (state == IDLE && state_nxt == REQ)
				step_inc <= (target_phase > cur_phase);
			if (ps_en)
				cur_phase <= step_inc ? cur_phase + PHASE_W'(1) : cur_phase - PHASE_W'(1);
		end
	end

	// Change flag two cycles late, lets the new target settle
	always_ff @(posedge CLK40 or posedge cmp_rst)
	begin
		if (cmp_rst)
		begin
			chg_m1 <= 1'b0;
			cmp_phs_change <= 1'b0;
		end
		else
		begin
			chg_m1 <= phase_diff;
			cmp_phs_change <= chg_m1;
		end
	end

	assign ps_en = (state == REQ);
	assign ps_incdec = step_inc;
	assign busy = phase_diff || (state != IDLE);

endmodule

// ==== hdl/samp_resync_ctrl.sv ====
module samp_resync_ctrl #(
	parameter int TICK_DIV = 40,
	parameter int HOLDOFF_US = 100
) (
	input  logic CLK40,
	input  logic RST,
	input  logic resync,
	input  logic [clk_ctrl_pkg::SAMP_SEL_W-1:0] samp_phase,
	input  logic samp_chng,
	output logic samp_mmcm_rst,
	output logic [1:0] samp_sel,
	output logic clk20_sel,
	output logic dsr_resync
);
	import clk_ctrl_pkg::*;

	localparam int PIPE_LEN = 8;
	localparam int TICK_W = $clog2(TICK_DIV + 1);
	localparam int HOLD_W = $clog2(HOLDOFF_US + 1);

	logic rst_d1;
	logic rst_d2;
	logic trl_edg_rst;
	logic resync_d1;
	logic lead_edg_resync;
	logic load_evt;
	logic [PIPE_LEN-1:0] rst_mmcm_pipe;
	logic cap_phase;
	logic cap_phase_d1;
	logic clk20_phase;
	logic c20_phase_sel;
	logic [TICK_W-1:0] tick_cnt;
	logic us_tick;
	logic [HOLD_W-1:0] dsr_ho_tmr;
	logic dsr_ho;
	logic clr_dsr_ho;

	// ------------------------------------------------------------------------
	// Realignment events
	// ------------------------------------------------------------------------

	// Reset tail, held high through reset, two cycles wide after it
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			rst_d1 <= 1'b1;
			rst_d2 <= 1'b1;
		end
		else
		begin
			rst_d1 <= 1'b0;
			rst_d2 <= rst_d1;
		end
	end

	assign trl_edg_rst = ~RST & rst_d2;
	assign lead_edg_resync = resync & ~resync_d1;
	assign load_evt = lead_edg_resync | trl_edg_rst | samp_chng;

	// Reset stretcher and capture strobe
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			resync_d1 <= 1'b0;
			rst_mmcm_pipe <= '0;
			cap_phase <= 1'b0;
			cap_phase_d1 <= 1'b0;
		end
		else
		begin
			resync_d1 <= resync;
			rst_mmcm_pipe <= {rst_mmcm_pipe[PIPE_LEN-2:0], load_evt};
			cap_phase <= load_evt;
			cap_phase_d1 <= cap_phase;
		end
	end

	// 20 MHz half-cycle parity, zeroed by a resync edge
	// Latched on the first cap_phase cycle only
	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			clk20_phase <= 1'b0;
			c20_phase_sel <= 1'b0;
		end
		else
		begin
			clk20_phase <= lead_edg_resync ? 1'b0 : ~clk20_phase;
			if (cap_phase && !cap_phase_d1)
				c20_phase_sel <= clk20_phase;
		end
	end

	// ------------------------------------------------------------------------
	// Microsecond holdoff
	// ------------------------------------------------------------------------
	assign us_tick = (tick_cnt == TICK_W'(TICK_DIV - 1));
	assign clr_dsr_ho = (dsr_ho_tmr == HOLD_W'(HOLDOFF_US));

	always_ff @(posedge CLK40 or posedge RST)
	begin
		if (RST)
		begin
			tick_cnt <= '0;
			dsr_ho_tmr <= '0;
			dsr_ho <= 1'b0;
		end
		else
		begin
			// Free-running divider
			tick_cnt <= us_tick ? '0 : tick_cnt + TICK_W'(1);
			// Restart on a new capture
			if (cap_phase || !dsr_ho)
				dsr_ho_tmr <= '0;
			else if (us_tick)
				dsr_ho_tmr <= dsr_ho_tmr + HOLD_W'(1);
			if (cap_phase)
				dsr_ho <= 1'b1;
			else if (clr_dsr_ho)
				dsr_ho <= 1'b0;
		end
	end

	assign samp_mmcm_rst = |rst_mmcm_pipe;
	assign samp_sel = samp_phase[1:0];
	// Top bit of the setting flips the captured parity
	assign clk20_sel = c20_phase_sel ^ samp_phase[SAMP_SEL_W-1];
	assign dsr_resync = dsr_ho;

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the clock-control testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_clk_ctrl -o sim_tb \
	&& ./obj_dir/sim_tb > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }

cat sim.log
grep -q '>>> FAIL' sim.log && exit 1
grep -q '>>> PASS' sim.log || exit 1
exit 0

// ==== tb.f ====
hdl/clk_ctrl_pkg.sv
hdl/clk_ctrl_regs.sv
hdl/cmp_phase_rom.sv
hdl/cmp_phase_stepper.sv
hdl/samp_resync_ctrl.sv
hdl/clk_ctrl_top.sv
tb/ps_mmcm_model.sv
tb/tb_clk_ctrl.sv

// ==== tb/ps_mmcm_model.sv ====
module ps_mmcm_model (
	input  logic CLK40,
	input  logic ps_en,
	input  logic lock_req,
	output logic ps_done,
	output logic locked,
	output logic pending
);
	timeunit 1ns;
	timeprecision 100ps;

	integer seed;
	int cnt;

	initial
	begin
		seed = 32'h04db_4251;
		ps_done = 1'b0;
		pending = 1'b0;
		cnt = 0;
	end

	// Lock follows the testbench control directly
	assign locked = lock_req;

	// One done pulse per request, 3 to 15 cycles later
	always @(posedge CLK40)
	begin
		ps_done <= 1'b0;
		if (ps_en && !pending)
		begin
			pending <= 1'b1;
			cnt <= 3 + int'($unsigned($random(seed)) % 13);
		end
		else if (pending)
		begin
			if (cnt <= 1)
			begin
				ps_done <= 1'b1;
				pending <= 1'b0;
			end
			else
				cnt <= cnt - 1;
		end
	end

endmodule

// ==== tb/tb_clk_ctrl.sv ====
module tb_clk_ctrl;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int TICK = 4;
	localparam int HOLD = 10;
	// About 20 cycles per fine step over the 217, 130 and 216 step moves
	// Four holdoffs and some slack on top
	localparam int WDOG_CYC = (217 + 130 + 216) * 20 + 4 * (HOLD + 1) * TICK + 3000;

	logic CLK40, RST, wb_cyc, wb_stb, wb_we, resync, lock_req;
	logic [1:0] wb_adr;
	logic [31:0] wb_dat_w, wb_dat_r;
	logic wb_ack, ps_en, ps_incdec, ps_done, cmp_locked, cmp_rst, mdl_pending;
	logic samp_mmcm_rst, clk20_sel, dsr_resync, cmp_phs_change, lock_prev, chg_prev;
	logic [1:0] samp_sel;
	int errors = 0, timeouts = 0, en_cnt = 0, up_cnt = 0, dn_cnt = 0, ack_cnt = 0;
	int rst_len = 0, rst_pulses = 0, dsr_len = 0, cur_code = 0, cur_samp = 0;
	int cyc_cnt = 0, wr_ack_cyc = 0, chg_rises = 0, chg_dly = 0;
	logic [31:0] rd;

	clk_ctrl_top #(.TICK_DIV(TICK), .HOLDOFF_US(HOLD)) u_clk_ctrl_top (
		.CLK40(CLK40), .RST(RST), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we),
		.wb_adr(wb_adr), .wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.resync(resync), .ps_en(ps_en), .ps_incdec(ps_incdec), .ps_done(ps_done),
		.cmp_locked(cmp_locked), .cmp_rst(cmp_rst), .samp_mmcm_rst(samp_mmcm_rst),
		.samp_sel(samp_sel), .clk20_sel(clk20_sel), .dsr_resync(dsr_resync),
		.cmp_phs_change(cmp_phs_change)
	);

	ps_mmcm_model u_mmcm (
		.CLK40(CLK40), .ps_en(ps_en), .lock_req(lock_req), .ps_done(ps_done),
		.locked(cmp_locked), .pending(mdl_pending)
	);

	initial
	begin
		CLK40 = 1'b0;
		forever #4 CLK40 = ~CLK40;
	end

	// Rounded table entry k * 1344 / 31
	function automatic int table_val(input int k);
		return (k * 2688 + 31) / 62;
	endfunction

	task automatic check_eq(input string name, input int exp, input int act);
		assert (exp == act) else
		begin
			errors++;
			$display("** Error: %s expected %0d actual %0d", name, exp, act);
		end
	endtask

	// ------------------------------------------------------------------------
	// Monitors sampled mid-cycle
	// ------------------------------------------------------------------------
	always @(negedge CLK40)
	begin
		if (ps_en)
		begin
			en_cnt++;
			if (ps_incdec)
				up_cnt++;
			else
				dn_cnt++;
		end
		assert (!(ps_en && mdl_pending)) else
		begin
			errors++;
			$display("ps_en issued while a done was still pending at %0t", $time);
		end
		assert (!(ps_en && RST)) else
		begin
			errors++;
			$display("ps_en pulsed during reset at %0t", $time);
		end
		// Request may already be out in the cycle lock drops
		assert (!(ps_en && !cmp_locked && !lock_prev)) else
		begin
			errors++;
			$display("ps_en issued while lock was low at %0t", $time);
		end
		lock_prev = cmp_locked;
		if (wb_ack)
			ack_cnt++;
		// Change flag latency from the last write ack
		if (wb_ack && wb_we)
			wr_ack_cyc = cyc_cnt;
		if (cmp_phs_change && !chg_prev)
		begin
			chg_rises++;
			chg_dly = cyc_cnt - wr_ack_cyc;
		end
		chg_prev = cmp_phs_change;
		cyc_cnt++;
		if (samp_mmcm_rst)
			rst_len++;
		else if (rst_len > 0)
		begin
			assert (rst_len >= 8) else
			begin
				errors++;
				$display("samp_mmcm_rst pulse only %0d cycles wide", rst_len);
			end
			rst_pulses++;
			rst_len = 0;
		end
		if (dsr_resync)
			dsr_len++;
		else if (dsr_len > 0)
		begin
			assert (dsr_len >= (HOLD - 1) * TICK && dsr_len <= (HOLD + 1) * TICK) else
			begin
				errors++;
				$display("dsr_resync holdoff lasted %0d cycles", dsr_len);
			end
			dsr_len = 0;
		end
	end

	// One classic access with the master holding cyc and stb until ack
	task automatic wb_access(input logic we, input logic [1:0] adr, input int wdat,
		output logic [31:0] rdat);
		int n;
		int acks0;
		@(posedge CLK40);
		#1;
		acks0 = ack_cnt;
		n = 0;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = 32'(wdat);
		do
		begin
			@(negedge CLK40);
			n++;
		end
		while (!wb_ack && n < 16);
		rdat = wb_dat_r;
		if (!wb_ack)
		begin
			timeouts++;
			$display("Wishbone access to address %0d got no ack", adr);
		end
		@(posedge CLK40);
		#1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		repeat (2) @(posedge CLK40);
		#1;
		check_eq("wb_ack_once", acks0 + 1, ack_cnt);
	endtask

	// Step to a new code and optionally drop lock part way
	task automatic move_to(input string name, input int code, input bit stall);
		int diff;
		int n;
		diff = table_val(code) - table_val(cur_code);
		en_cnt = 0;
		up_cnt = 0;
		dn_cnt = 0;
		chg_rises = 0;
		cur_code = code;
		wb_access(1'b1, 2'd0, (cur_samp << 8) | code, rd);
		if (stall)
		begin
			n = 0;
			while (en_cnt < 20 && n < 2000)
			begin
				@(posedge CLK40);
				n++;
			end
			#1;
			lock_req = 1'b0;
			repeat (40) @(posedge CLK40);
			wb_access(1'b0, 2'd1, 0, rd);
			check_eq({name, "_busy_stalled"}, 1, int'(rd[12]));
			lock_req = 1'b1;
		end
		n = 0;
		rd = 32'h0000_1000;
		while (rd[12] && n < 4000)
		begin
			wb_access(1'b0, 2'd1, 0, rd);
			n++;
		end
		if (rd[12])
		begin
			timeouts++;
			$display("%s never went idle", name);
		end
		check_eq({name, "_phase"}, table_val(code), int'(rd[10:0]));
		check_eq({name, "_steps"}, (diff < 0) ? -diff : diff, en_cnt);
		check_eq({name, "_up"}, (diff > 0) ? diff : 0, up_cnt);
		check_eq({name, "_down"}, (diff < 0) ? -diff : 0, dn_cnt);
		// Target trails the code by one cycle and the flag trails the target by two
		check_eq({name, "_chg_rises"}, 1, chg_rises);
		check_eq({name, "_chg_delay"}, 3, chg_dly);
		check_eq({name, "_chg_end"}, 0, int'(cmp_phs_change));
	endtask

	// Resync edge followed by the full holdoff
	task automatic do_resync(input string name);
		int pulses0;
		int n;
		pulses0 = rst_pulses;
		resync = 1'b1;
		repeat (3) @(posedge CLK40);
		#1;
		resync = 1'b0;
		n = 0;
		while (!dsr_resync && n < 20)
		begin
			@(posedge CLK40);
			n++;
		end
		#1;
		check_eq({name, "_dsr_rise"}, 1, int'(dsr_resync));
		check_eq({name, "_clk20_sel"}, cur_samp >> 2, int'(clk20_sel));
		n = 0;
		while (dsr_resync && n < (HOLD + 4) * TICK)
		begin
			@(posedge CLK40);
			n++;
		end
		repeat (4) @(posedge CLK40);
		#1;
		check_eq({name, "_dsr_fall"}, 0, int'(dsr_resync));
		check_eq({name, "_rst_pulses"}, pulses0 + 1, rst_pulses);
	endtask

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------
	initial
	begin
		int pulses0;
		RST = 1'b1;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 32'd0;
		resync = 1'b0;
		lock_req = 1'b1;
		lock_prev = 1'b1;
		chg_prev = 1'b0;
		repeat (5) @(posedge CLK40);
		#1;
		check_eq("reset_cmp_rst", 1, int'(cmp_rst));
		RST = 1'b0;
		// Let the end-of-reset holdoff run out
		repeat ((HOLD + 3) * TICK) @(posedge CLK40);
		wb_access(1'b0, 2'd1, 0, rd);
		check_eq("reset_phase", 0, int'(rd[10:0]));
		check_eq("reset_busy", 0, int'(rd[12]));
		check_eq("reset_state", 0, int'(rd[18:16]));
		check_eq("reset_ps_en", 0, en_cnt);
		check_eq("reset_cmp_rst_low", 0, int'(cmp_rst));
		check_eq("reset_phs_change", 0, int'(cmp_phs_change));
		check_eq("reset_samp_rst", 0, int'(samp_mmcm_rst));
		check_eq("reset_holdoff", 0, int'(dsr_resync));
		move_to("step_up", 5, 1'b0);
		move_to("step_down", 2, 1'b0);
		move_to("lock_stall", 7, 1'b1);
		// Soft reset together with code 0 leaves nothing to step after release
		en_cnt = 0;
		cur_code = 0;
		wb_access(1'b1, 2'd0, (1 << 16) | (cur_samp << 8), rd);
		check_eq("soft_rst_cmp_rst", 1, int'(cmp_rst));
		wb_access(1'b0, 2'd0, 0, rd);
		check_eq("soft_rst_ctrl", (1 << 16) | (cur_samp << 8), int'(rd));
		wb_access(1'b0, 2'd1, 0, rd);
		check_eq("soft_rst_phase", 0, int'(rd[10:0]));
		check_eq("soft_rst_state", 0, int'(rd[18:16]));
		wb_access(1'b1, 2'd0, cur_samp << 8, rd);
		check_eq("soft_rst_release", 0, int'(cmp_rst));
		check_eq("soft_rst_ps_en", 0, en_cnt);
		do_resync("resync_a");
		// Only a changed sample phase realigns
		pulses0 = rst_pulses;
		cur_samp = 6;
		wb_access(1'b1, 2'd0, (cur_samp << 8) | cur_code, rd);
		repeat (16) @(posedge CLK40);
		#1;
		check_eq("samp_sel", cur_samp & 3, int'(samp_sel));
		check_eq("samp_chng_pulse", pulses0 + 1, rst_pulses);
		wb_access(1'b1, 2'd0, (cur_samp << 8) | cur_code, rd);
		repeat (16) @(posedge CLK40);
		#1;
		check_eq("samp_same_no_pulse", pulses0 + 1, rst_pulses);
		repeat ((HOLD + 2) * TICK) @(posedge CLK40);
		#1;
		do_resync("resync_b");
		$display("Summary: %0d check errors, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(WDOG_CYC * 8);
		$display("Watchdog expired, the run did not finish in time");
		$display(">>> FAIL");
		$finish;
	end

endmodule
